// File: hw/isa_pkg.sv
package isa_pkg;

    localparam int xlen = 32;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        op     = 7'b0110011,
        op_imm = 7'b0010011,
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        branch = 7'b1100011
    } opcode_e;

    // ALU funct3
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // Branch funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // Field positions, lowest bit of each field
    localparam int opcode_lsb = 0;
    localparam int rd_lsb     = 7;
    localparam int funct3_lsb = 12;
    localparam int rs1_lsb    = 15;
    localparam int rs2_lsb    = 20;
    localparam int funct7_lsb = 25;
    localparam int funct7_alt_bit = 30;

    localparam logic [xlen-1:0] link_offset = 32'd4;

endpackage

// File: hw/pipe_pkg.sv
package pipe_pkg;

    typedef enum logic [3:0] {
        add,
        sub,
        slt,
        sltu,
        and_op,
        or_op,
        xor_op,
        sll,
        srl,
        sra,
        nop
    } alu_op_e;

    typedef struct packed {
        logic [isa_pkg::xlen-1:0] instr;
        logic [isa_pkg::xlen-1:0] pc;
        logic [isa_pkg::xlen-1:0] rs1_data;
        logic [isa_pkg::xlen-1:0] rs2_data;
    } fetch_packet_t;

    typedef struct packed {
        alu_op_e                  alu_op;
        logic [isa_pkg::xlen-1:0] op1;
        logic [isa_pkg::xlen-1:0] op2;
        logic [4:0]               rd;
        logic                     wb;
        logic                     illegal;
    } decode_t;

    typedef struct packed {
        logic                     taken;
        logic [isa_pkg::xlen-1:0] target;
    } branch_t;

    // Entry towards execute
    typedef struct packed {
        alu_op_e                  alu_op;
        logic [isa_pkg::xlen-1:0] op1;
        logic [isa_pkg::xlen-1:0] op2;
        logic [4:0]               rd;
        logic                     wb;
        logic                     illegal;
        logic [isa_pkg::xlen-1:0] pc;
        logic                     branch_taken;
    } exe_op_t;

    typedef struct packed {
        logic                     valid;
        logic [isa_pkg::xlen-1:0] target;
    } redirect_t;

    localparam int queue_depth = 4;
    localparam int queue_ptr_w = $clog2(queue_depth);
    localparam int queue_cnt_w = $clog2(queue_depth + 1);

endpackage

// File: hw/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
    input  pipe_pkg::fetch_packet_t in_pkt,
    output pipe_pkg::decode_t       dec
);

    logic [isa_pkg::xlen-1:0] instr;
    isa_pkg::opcode_e         opcode;
    logic [2:0]               funct3;
    logic [6:0]               funct7;
    logic                     alt;
    logic                     f7_zero;
    logic                     f7_alt_ok;
    logic                     is_imm;
    logic [isa_pkg::xlen-1:0] imm_i;
    logic [isa_pkg::xlen-1:0] imm_u;
    pipe_pkg::alu_op_e        alu_sel;
    logic                     alu_legal;
    logic                     branch_f3_ok;

    assign instr  = in_pkt.instr;
    assign opcode = isa_pkg::opcode_e'(instr[isa_pkg::opcode_lsb +: 7]);
    assign funct3 = instr[isa_pkg::funct3_lsb +: 3];
    assign funct7 = instr[isa_pkg::funct7_lsb +: 7];
    assign alt    = instr[isa_pkg::funct7_alt_bit];
    assign is_imm = (opcode == isa_pkg::op_imm);

    // funct7 is either all zero or has only the sub/sra bit set
    assign f7_zero   = (funct7 == 7'b0000000);
    assign f7_alt_ok = f7_zero || (funct7 == 7'b0100000);

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};

    assign branch_f3_ok = funct3 inside {isa_pkg::f3_beq, isa_pkg::f3_bne, isa_pkg::f3_blt,
                                         isa_pkg::f3_bge, isa_pkg::f3_bltu, isa_pkg::f3_bgeu};

    // ---------------------------------------------------------------------
    // ALU operation from funct3 and funct7
    // ---------------------------------------------------------------------
    always_comb begin
        alu_sel   = pipe_pkg::nop;
        alu_legal = 1'b1;
        case (funct3)
            isa_pkg::f3_add_sub: begin
                // addi has no funct7, its bits are immediate
                if (!is_imm && alt) begin
                    alu_sel = pipe_pkg::sub;
                end else begin
                    alu_sel = pipe_pkg::add;
                end
                alu_legal = is_imm || f7_alt_ok;
            end
            isa_pkg::f3_sll: begin
                alu_sel   = pipe_pkg::sll;
                alu_legal = f7_zero;
            end
            isa_pkg::f3_slt: begin
                alu_sel   = pipe_pkg::slt;
                alu_legal = is_imm || f7_zero;
            end
            isa_pkg::f3_sltu: begin
                alu_sel   = pipe_pkg::sltu;
                alu_legal = is_imm || f7_zero;
            end
            isa_pkg::f3_xor: begin
                alu_sel   = pipe_pkg::xor_op;
                alu_legal = is_imm || f7_zero;
            end
            isa_pkg::f3_srl_sra: begin
                if (alt) begin
                    alu_sel = pipe_pkg::sra;
                end else begin
                    alu_sel = pipe_pkg::srl;
                end
                alu_legal = f7_alt_ok;
            end
            isa_pkg::f3_or: begin
                alu_sel   = pipe_pkg::or_op;
                alu_legal = is_imm || f7_zero;
            end
            default: begin
                alu_sel   = pipe_pkg::and_op;
                alu_legal = is_imm || f7_zero;
            end
        endcase
    end

    // ---------------------------------------------------------------------
    // Operands and write-back
    // ---------------------------------------------------------------------
    always_comb begin
        dec        = '0;
        dec.alu_op = pipe_pkg::nop;
        case (opcode)
            isa_pkg::op, isa_pkg::op_imm: begin
                if (alu_legal) begin
                    dec.alu_op = alu_sel;
                    dec.op1    = in_pkt.rs1_data;
                    dec.op2    = is_imm ? imm_i : in_pkt.rs2_data;
                    dec.wb     = 1'b1;
                end else begin
                    dec.illegal = 1'b1;
                end
            end
            isa_pkg::lui: begin
                dec.alu_op = pipe_pkg::add;
                dec.op1    = imm_u;
                dec.wb     = 1'b1;
            end
            isa_pkg::auipc: begin
                dec.alu_op = pipe_pkg::add;
                dec.op1    = in_pkt.pc;
                dec.op2    = imm_u;
                dec.wb     = 1'b1;
            end
            isa_pkg::jal, isa_pkg::jalr: begin
                // Link value pc + 4
                dec.alu_op = pipe_pkg::add;
                dec.op1    = in_pkt.pc;
                dec.op2    = isa_pkg::link_offset;
                dec.wb     = 1'b1;
            end
            isa_pkg::branch: begin
                dec.illegal = !branch_f3_ok;
            end
            default: begin
                dec.illegal = 1'b1;
            end
        endcase
        dec.rd = dec.wb ? instr[isa_pkg::rd_lsb +: 5] : 5'd0;
    end

endmodule

// File: hw/branch_unit.sv
`timescale 1ns/10ps

module branch_unit (
    input  pipe_pkg::fetch_packet_t in_pkt,
    output pipe_pkg::branch_t       br
);

    isa_pkg::opcode_e         opcode;
    logic [2:0]               funct3;
    logic [isa_pkg::xlen-1:0] instr;
    logic [isa_pkg::xlen-1:0] imm_b;
    logic [isa_pkg::xlen-1:0] imm_j;
    logic [isa_pkg::xlen-1:0] imm_i;
    logic [isa_pkg::xlen-1:0] jalr_sum;
    logic                     eq;
    logic                     lt;
    logic                     ltu;

    assign instr  = in_pkt.instr;
    assign opcode = isa_pkg::opcode_e'(instr[isa_pkg::opcode_lsb +: 7]);
    assign funct3 = instr[isa_pkg::funct3_lsb +: 3];

    // Scattered immediates of B and J formats
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_i = {{20{instr[31]}}, instr[31:20]};

    assign jalr_sum = in_pkt.rs1_data + imm_i;

    assign eq  = (in_pkt.rs1_data == in_pkt.rs2_data);
    assign lt  = ($signed(in_pkt.rs1_data) < $signed(in_pkt.rs2_data));
    assign ltu = (in_pkt.rs1_data < in_pkt.rs2_data);

    always_comb begin
        br.taken  = 1'b0;
        br.target = '0;
        case (opcode)
            isa_pkg::branch: begin
                br.target = in_pkt.pc + imm_b;
                case (funct3)
                    isa_pkg::f3_beq:  br.taken = eq;
                    isa_pkg::f3_bne:  br.taken = !eq;
                    isa_pkg::f3_blt:  br.taken = lt;
                    isa_pkg::f3_bge:  br.taken = !lt;
                    isa_pkg::f3_bltu: br.taken = ltu;
                    isa_pkg::f3_bgeu: br.taken = !ltu;
                    default:          br.taken = 1'b0;
                endcase
            end
            isa_pkg::jal: begin
                br.taken  = 1'b1;
                br.target = in_pkt.pc + imm_j;
            end
            isa_pkg::jalr: begin
                br.taken  = 1'b1;
                br.target = {jalr_sum[isa_pkg::xlen-1:1], 1'b0};
            end
            default: begin
                br.taken = 1'b0;
            end
        endcase

        // Relies on fetch delivering halfword aligned pcs
        if (br.taken) begin
            assert (br.target[0] == 1'b0)
                else $error("taken target %h has bit 0 set", br.target);
        end
    end

endmodule

// File: hw/issue_queue.sv
`timescale 1ns/10ps

module issue_queue (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic [isa_pkg::xlen-1:0] pc,
    input  pipe_pkg::decode_t        dec,
    input  pipe_pkg::branch_t        br,
    output logic                     out_valid,
    input  logic                     out_ready,
    output pipe_pkg::exe_op_t        out_op,
    output pipe_pkg::redirect_t      redirect
);

    pipe_pkg::exe_op_t                entry_in;
    pipe_pkg::exe_op_t                mem [pipe_pkg::queue_depth];
    logic [pipe_pkg::queue_ptr_w-1:0] rd_ptr;
    logic [pipe_pkg::queue_ptr_w-1:0] wr_ptr;
    logic [pipe_pkg::queue_cnt_w-1:0] count;
    logic                             push;
    logic                             pop;
    logic                             redirect_valid;
    logic [isa_pkg::xlen-1:0]         redirect_target;

    assign entry_in = '{alu_op: dec.alu_op, op1: dec.op1, op2: dec.op2, rd: dec.rd,
                        wb: dec.wb, illegal: dec.illegal, pc: pc, branch_taken: br.taken};

    // A pop does not free a slot until the next cycle
    assign in_ready  = (int'(count) < pipe_pkg::queue_depth);
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_op    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= entry_in;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ---------------------------------------------------------------------
    // Redirect towards fetch, one cycle pulse per taken accept
    // ---------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= push && br.taken;
        end
    end

    always_ff @(posedge clk) begin
        if (push && br.taken) begin
            redirect_target <= br.target;
        end
    end

    assign redirect = '{valid: redirect_valid, target: redirect_target};

    count_bound: assert property (@(posedge clk) disable iff (!reset_n)
        int'(count) <= pipe_pkg::queue_depth);

    out_hold: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid && !out_ready |=> out_valid && $stable(out_op));

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  pipe_pkg::fetch_packet_t in_pkt,
    output logic                    out_valid,
    input  logic                    out_ready,
    output pipe_pkg::exe_op_t       out_op,
    output pipe_pkg::redirect_t     redirect
);

    pipe_pkg::decode_t dec;
    pipe_pkg::branch_t br;

    // Decoder and branch unit see the same fetched packet
    instr_decoder instr_decoder_inst (
        .in_pkt (in_pkt),
        .dec    (dec)
    );

    branch_unit branch_unit_inst (
        .in_pkt (in_pkt),
        .br     (br)
    );

    issue_queue issue_queue_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .pc        (in_pkt.pc),
        .dec       (dec),
        .br        (br),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_op    (out_op),
        .redirect  (redirect)
    );

endmodule

// File: verification/decode_stage_tb.sv
`timescale 1ns/10ps

module decode_stage_tb;

    localparam int num_instr   = 2000;
    localparam int cycle_limit = num_instr * 8 + 200;
    localparam int num_tests   = 7;

    logic                    clk = 1'b0;
    logic                    reset_n;
    logic                    in_valid;
    logic                    in_ready;
    pipe_pkg::fetch_packet_t in_pkt;
    logic                    out_valid;
    logic                    out_ready = 1'b0;
    pipe_pkg::exe_op_t       out_op;
    pipe_pkg::redirect_t     redirect;

    // Scoreboard state
    pipe_pkg::exe_op_t        exp_q[$];
    int                       kind_q[$];
    int                       redir_tag_q[$];
    logic [isa_pkg::xlen-1:0] redir_tgt_q[$];
    int   cycle = 0;
    int   held = 0;
    int   stall_left = 0;
    logic fire_in = 1'b0;
    logic reset_checked = 1'b0;
    int   check_cnt [num_tests] = '{default: 0};
    int   error_cnt [num_tests] = '{default: 0};

    always #2 clk = ~clk;

    decode_stage decode_stage_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pkt    (in_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_op    (out_op),
        .redirect  (redirect)
    );

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------
    function automatic void decode_ref(input pipe_pkg::fetch_packet_t p,
                                       output pipe_pkg::exe_op_t e,
                                       output pipe_pkg::redirect_t r);
        logic [31:0] w;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic        is_r;
        logic        ok;
        w        = p.instr;
        f3       = w[14:12];
        f7       = w[31:25];
        imm_i    = {{20{w[31]}}, w[31:20]};
        imm_u    = {w[31:12], 12'b0};
        imm_b    = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j    = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        is_r     = (w[6:0] == isa_pkg::op);
        e        = '0;
        e.alu_op = pipe_pkg::nop;
        e.pc     = p.pc;
        r        = '0;
        case (w[6:0])
            isa_pkg::op, isa_pkg::op_imm: begin
                case (f3)
                    3'b000:  e.alu_op = (is_r && f7 == 7'h20) ? pipe_pkg::sub : pipe_pkg::add;
                    3'b001:  e.alu_op = pipe_pkg::sll;
                    3'b010:  e.alu_op = pipe_pkg::slt;
                    3'b011:  e.alu_op = pipe_pkg::sltu;
                    3'b100:  e.alu_op = pipe_pkg::xor_op;
                    3'b101:  e.alu_op = (f7 == 7'h20) ? pipe_pkg::sra : pipe_pkg::srl;
                    3'b110:  e.alu_op = pipe_pkg::or_op;
                    default: e.alu_op = pipe_pkg::and_op;
                endcase
                // I-type checks funct7 on shifts only
                if (f3 == 3'b001) begin
                    ok = (f7 == 7'h00);
                end else if (f3 == 3'b101 || (is_r && f3 == 3'b000)) begin
                    ok = (f7 == 7'h00 || f7 == 7'h20);
                end else begin
                    ok = !is_r || f7 == 7'h00;
                end
                if (ok) begin
                    e.op1 = p.rs1_data;
                    e.op2 = is_r ? p.rs2_data : imm_i;
                    e.wb  = 1'b1;
                end else begin
                    e.alu_op  = pipe_pkg::nop;
                    e.illegal = 1'b1;
                end
            end
            isa_pkg::lui: begin
                e.alu_op = pipe_pkg::add;
                e.op1    = imm_u;
                e.wb     = 1'b1;
            end
            isa_pkg::auipc: begin
                e.alu_op = pipe_pkg::add;
                e.op1    = p.pc;
                e.op2    = imm_u;
                e.wb     = 1'b1;
            end
            isa_pkg::jal, isa_pkg::jalr: begin
                e.alu_op = pipe_pkg::add;
                e.op1    = p.pc;
                e.op2    = 32'd4;
                e.wb     = 1'b1;
                r.valid  = 1'b1;
                if (w[6:0] == isa_pkg::jal) begin
                    r.target = p.pc + imm_j;
                end else begin
                    r.target = (p.rs1_data + imm_i) & ~32'd1;
                end
            end
            isa_pkg::branch: begin
                case (f3)
                    3'b000:  r.valid = (p.rs1_data == p.rs2_data);
                    3'b001:  r.valid = (p.rs1_data != p.rs2_data);
                    3'b100:  r.valid = ($signed(p.rs1_data) < $signed(p.rs2_data));
                    3'b101:  r.valid = ($signed(p.rs1_data) >= $signed(p.rs2_data));
                    3'b110:  r.valid = (p.rs1_data < p.rs2_data);
                    3'b111:  r.valid = (p.rs1_data >= p.rs2_data);
                    default: e.illegal = 1'b1;
                endcase
                r.target = p.pc + imm_b;
            end
            default: begin
                e.illegal = 1'b1;
            end
        endcase
        if (e.wb) begin
            e.rd = w[11:7];
        end
        e.branch_taken = r.valid;
    endfunction

    function automatic int classify(input logic [31:0] w, input logic illegal);
        if (illegal) begin
            return 4;
        end
        case (w[6:0])
            isa_pkg::op, isa_pkg::op_imm: return 1;
            isa_pkg::branch:              return 3;
            default:                      return 2;
        endcase
    endfunction

    function automatic string test_label(input int t);
        case (t)
            0:       return "reset";
            1:       return "alu commands";
            2:       return "lui auipc jal jalr";
            3:       return "branch resolution";
            4:       return "illegal encodings";
            5:       return "redirects";
            default: return "back-pressure";
        endcase
    endfunction

    function automatic logic [31:0] make_instr();
        logic [31:0] w;
        logic [6:0]  f7;
        w  = $urandom;
        f7 = {1'b0, w[30], 5'b0};
        if ($urandom_range(99) < 5) begin
            // Opcodes outside the kept set
            case (w[8:7])
                2'b00:   w[6:0] = 7'b0000011;
                2'b01:   w[6:0] = 7'b0100011;
                2'b10:   w[6:0] = 7'b1110011;
                default: w[6:0] = 7'b0001111;
            endcase
        end else begin
            case ($urandom_range(6))
                0: begin
                    w[6:0] = isa_pkg::op;
                    // Now and then keep a random funct7
                    if ($urandom_range(15) != 0) begin
                        w[31:25] = (w[14:12] == 3'b000 || w[14:12] == 3'b101) ? f7 : 7'h00;
                    end
                end
                1: begin
                    w[6:0] = isa_pkg::op_imm;
                    if ($urandom_range(15) != 0 && w[13:12] == 2'b01) begin
                        w[31:25] = w[14] ? f7 : 7'h00;
                    end
                end
                2: w[6:0] = isa_pkg::lui;
                3: w[6:0] = isa_pkg::auipc;
                4: w[6:0] = isa_pkg::jal;
                5: begin
                    w[6:0]   = isa_pkg::jalr;
                    w[14:12] = 3'b000;
                end
                default: w[6:0] = isa_pkg::branch;
            endcase
        end
        return w;
    endfunction

    task automatic compare(input int t, input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        check_cnt[t]++;
        if (expected !== actual) begin
            error_cnt[t]++;
            $display("** Error at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic note_failure(input int t, input string text);
        check_cnt[t]++;
        error_cnt[t]++;
        $display("Failure at %0t: %s", $time, text);
    endtask

    // ----------------------------------------------------------------------
    // Monitor and scoreboard, sampled on the falling edge
    // ----------------------------------------------------------------------
    always @(negedge clk) begin
        pipe_pkg::exe_op_t   exp;
        pipe_pkg::redirect_t rexp;
        logic                due;
        logic                leaving;
        int                  t;
        fire_in = in_valid && in_ready;
        if (reset_n) begin
            if (!reset_checked) begin
                reset_checked = 1'b1;
                compare(0, "out_valid", 32'd0, 32'(out_valid));
                compare(0, "redirect.valid", 32'd0, 32'(redirect.valid));
                compare(0, "in_ready", 32'd1, 32'(in_ready));
                $display("test %s: %0d checks, %0d errors", test_label(0), check_cnt[0],
                         error_cnt[0]);
            end
            // Redirect is due one cycle after its accepting edge
            due = (redir_tag_q.size() != 0) && (redir_tag_q[0] == cycle);
            if (due && redirect.valid) begin
                compare(5, "redirect.target", redir_tgt_q[0], redirect.target);
            end else if (due) begin
                note_failure(5, "expected redirect did not appear");
            end else if (redirect.valid) begin
                note_failure(5, "redirect appeared without a taken instruction");
            end
            if (due) begin
                void'(redir_tag_q.pop_front());
                void'(redir_tgt_q.pop_front());
            end
            compare(6, "in_ready", 32'(held < pipe_pkg::queue_depth), 32'(in_ready));
            compare(6, "out_valid", 32'(held != 0), 32'(out_valid));
            leaving = out_valid && out_ready;
            if (leaving && exp_q.size() == 0) begin
                note_failure(6, "entry left the stage with none expected");
            end else if (leaving) begin
                exp = exp_q.pop_front();
                t   = kind_q.pop_front();
                compare(t, "out_op.alu_op", 32'(exp.alu_op), 32'(out_op.alu_op));
                compare(t, "out_op.op1", exp.op1, out_op.op1);
                compare(t, "out_op.op2", exp.op2, out_op.op2);
                compare(t, "out_op.rd", 32'(exp.rd), 32'(out_op.rd));
                compare(t, "out_op.wb", 32'(exp.wb), 32'(out_op.wb));
                compare(t, "out_op.illegal", 32'(exp.illegal), 32'(out_op.illegal));
                compare(t, "out_op.pc", exp.pc, out_op.pc);
                compare(t, "out_op.branch_taken", 32'(exp.branch_taken),
                        32'(out_op.branch_taken));
            end
            if (fire_in) begin
                decode_ref(in_pkt, exp, rexp);
                exp_q.push_back(exp);
                kind_q.push_back(classify(in_pkt.instr, exp.illegal));
                if (rexp.valid) begin
                    redir_tag_q.push_back(cycle + 1);
                    redir_tgt_q.push_back(rexp.target);
                end
            end
            held = held + (fire_in ? 1 : 0) - (leaving ? 1 : 0);
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // Execute side, with occasional long stalls
    always @(posedge clk) begin
        if (stall_left > 0) begin
            stall_left <= stall_left - 1;
            out_ready  <= 1'b0;
        end else if ($urandom_range(63) == 0) begin
            stall_left <= int'($urandom_range(40, 15));
            out_ready  <= 1'b0;
        end else begin
            out_ready <= ($urandom_range(3) != 0);
        end
    end

    initial begin
        pipe_pkg::fetch_packet_t pkt;
        int                      issued;
        int                      total_checks;
        int                      total_errors;
        void'($urandom(32'h6681));
        reset_n      = 1'b0;
        in_valid     = 1'b0;
        in_pkt       = '0;
        issued       = 0;
        total_checks = 0;
        total_errors = 0;
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        while (issued < num_instr) begin
            @(posedge clk);
            if (fire_in) begin
                issued++;
            end
            // Packet holds until accepted
            if (!in_valid || fire_in) begin
                if (issued < num_instr && $urandom_range(3) != 0) begin
                    pkt.instr    = make_instr();
                    pkt.pc       = $urandom & 32'hffff_fffc;
                    pkt.rs1_data = $urandom;
                    pkt.rs2_data = ($urandom_range(3) == 0) ? pkt.rs1_data : $urandom;
                    in_valid <= 1'b1;
                    in_pkt   <= pkt;
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end
        while (exp_q.size() != 0 || redir_tag_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);
        for (int i = 0; i < num_tests; i++) begin
            total_checks += check_cnt[i];
            total_errors += error_cnt[i];
            if (i > 0) begin
                $display("test %s: %0d checks, %0d errors", test_label(i), check_cnt[i],
                         error_cnt[i]);
            end
        end
        $display("Total: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0 && reset_checked && total_checks > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/instr_decoder.sv
hw/branch_unit.sv
hw/issue_queue.sv
hw/decode_stage.sv
verification/decode_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module decode_stage_tb -f project.f \
    -o decode_stage_sim && ./obj_dir/decode_stage_sim > sim.log 2>&1 \
    || echo "CHECKS FAILED" >> sim.log
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0
